//--- sim.f
+incdir+common
common/boot_pkg.sv
source/io_fifo.sv
loader/nbf_loader.sv
source/load_arbiter.sv
source/io_router.sv
mem/io_mem.sv
host/host_mmio.sv
source/boot_top.sv
tb/boot_tb_checker.sv
tb/boot_tb.sv

//--- tb/boot_tb.sv
// Testbench for the boot subsystem with a shadow memory model and an ordered compare
`include "boot_macros.svh"

module boot_tb;
   timeunit 1ns;
   timeprecision 1ns;
   import boot_pkg::*;

   localparam int n_load = 40;
   localparam int n_mixed = 60;
   // Loads plus finish, reads, two mixed runs, putchar and finish accesses
   localparam int n_trans = n_load + 1 + n_load + 8 + 2 * n_mixed + 6 + 2;
   localparam int timeout_cycles = n_trans * 40 + 10;

   logic       clk_i;
   logic       arst_n_i;
   nbf_rec_t   nbf_rec;
   logic       nbf_rec_v;
   logic       nbf_rec_ready;
   io_cmd_t    proc_cmd;
   logic       proc_cmd_v;
   logic       proc_cmd_ready;
   io_resp_t   proc_resp;
   logic       proc_resp_v;
   logic       proc_resp_ready;
   logic       nbf_done;
   logic [7:0] char_val;
   logic       char_v;
   logic       program_finish;

   logic [`BOOT_DATA_W-1:0] shadow [`BOOT_MEM_WORDS];
   bit          written [`BOOT_MEM_WORDS];
   bit          model_finish;
   io_resp_t    exp_resp_q [$];
   logic [7:0]  exp_char_q [$];
   logic [31:0] stim_state;
   logic [31:0] gap_state;
   bit          gaps_on;

   boot_top u_boot_top
   (
      .clk_i             (clk_i),
      .arst_n_i          (arst_n_i),
      .nbf_rec_i         (nbf_rec),
      .nbf_rec_v_i       (nbf_rec_v),
      .nbf_rec_ready_o   (nbf_rec_ready),
      .proc_cmd_i        (proc_cmd),
      .proc_cmd_v_i      (proc_cmd_v),
      .proc_cmd_ready_o  (proc_cmd_ready),
      .proc_resp_o       (proc_resp),
      .proc_resp_v_o     (proc_resp_v),
      .proc_resp_ready_i (proc_resp_ready),
      .nbf_done_o        (nbf_done),
      .char_o            (char_val),
      .char_v_o          (char_v),
      .program_finish_o  (program_finish)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Host reads give the finish state and memory reads the shadow word or zero
   function automatic logic [`BOOT_DATA_W-1:0] model_read(input logic [`BOOT_ADDR_W-1:0] addr);
      if (addr >= `BOOT_HOST_BASE)
         return {{(`BOOT_DATA_W-1){1'b0}}, model_finish};
      else if (written[addr % `BOOT_MEM_WORDS])
         return shadow[addr % `BOOT_MEM_WORDS];
      else
         return '0;
   endfunction

   function automatic io_resp_t expect_resp(input io_cmd_t c);
      io_resp_t r;
      r.op   = c.op;
      r.addr = c.addr;
      r.data = (c.op == IO_WRITE) ? c.data : model_read(c.addr);
      return r;
   endfunction

   task automatic apply_write(input io_cmd_t c);
      if (c.op == IO_WRITE)
      begin
         if (c.addr < `BOOT_HOST_BASE)
         begin
            shadow[c.addr % `BOOT_MEM_WORDS]  = c.data;
            written[c.addr % `BOOT_MEM_WORDS] = 1'b1;
         end
         else if (c.addr == `BOOT_PUTCHAR_ADDR)
            exp_char_q.push_back(c.data[7:0]);
         else if (c.addr == `BOOT_FINISH_ADDR)
            model_finish = 1'b1;
      end
   endtask

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "%s", msg);
   endtask

   task automatic check_resp(input io_resp_t got, input io_resp_t exp);
      if (got !== exp)
      begin
         $display("ERROR at %0t ns: proc_resp_o expected %h got %h", $time, exp, got);
         $display("TEST RESULT: FAIL");
         $fatal(1, "response mismatch");
      end
   endtask

   task automatic check_char(input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
      begin
         $display("ERROR at %0t ns: char_o expected %h got %h", $time, exp, got);
         $display("TEST RESULT: FAIL");
         $fatal(1, "character mismatch");
      end
   endtask

   // Entered and left 10 ns after a rising edge
   task automatic send_rec(input nbf_rec_t r);
      nbf_rec   = r;
      nbf_rec_v = 1'b1;
      forever
      begin
         @(negedge clk_i);
         if (nbf_rec_ready)
            break;
      end
      @(posedge clk_i);
      #10;
      nbf_rec_v = 1'b0;
   endtask

   task automatic send_cmd(input io_op_e kind, input logic [15:0] a, input logic [31:0] d);
      io_cmd_t c;
      c.op       = kind;
      c.addr     = a;
      c.data     = d;
      proc_cmd   = c;
      proc_cmd_v = 1'b1;
      forever
      begin
         @(negedge clk_i);
         if (proc_cmd_ready)
            break;
      end
      @(posedge clk_i);
      #10;
      proc_cmd_v = 1'b0;
      exp_resp_q.push_back(expect_resp(c));
      apply_write(c);
   endtask

   task automatic run_mixed(input int n);
      logic [31:0] d;
      for (int i = 0; i < n; i++)
      begin
         stim_state = xorshift(stim_state);
         d = xorshift(stim_state);
         send_cmd(stim_state[8] ? IO_WRITE : IO_READ, {8'h00, stim_state[7:0]}, d);
         stim_state = d;
      end
   endtask

   task automatic drain_resps();
      while (exp_resp_q.size() != 0)
      begin
         @(posedge clk_i);
         #10;
      end
   endtask

   initial
   begin
      clk_i = 1'b0;
      forever
         #50 clk_i = ~clk_i;
   end

   // Response ready with random gaps when enabled
   initial
   begin
      gap_state       = 32'd71;
      proc_resp_ready = 1'b1;
      forever
      begin
         @(posedge clk_i);
         #10;
         if (gaps_on)
         begin
            gap_state       = xorshift(gap_state);
            proc_resp_ready = (gap_state[1:0] != 2'b00);
         end
         else
            proc_resp_ready = 1'b1;
      end
   end

   // Compare process sampling mid-cycle where everything is settled
   initial
   begin
      forever
      begin
         @(negedge clk_i);
         if (!nbf_done && proc_cmd_ready)
            fail_run("proc_cmd_ready_o went high before nbf_done_o");
         else if (proc_resp_v && proc_resp_ready)
         begin
            if (exp_resp_q.size() == 0)
               fail_run("a response arrived with no command outstanding");
            else
               check_resp(proc_resp, exp_resp_q.pop_front());
         end
         if (char_v)
         begin
            if (exp_char_q.size() == 0)
               fail_run("char_v_o pulsed with no putchar write outstanding");
            else
               check_char(char_val, exp_char_q.pop_front());
         end
      end
   end

   initial
   begin
      #(timeout_cycles * 100);
      fail_run("Timeout: the run did not complete in the allowed time");
   end

   initial
   begin
      nbf_rec_t    rec;
      io_cmd_t     c;
      logic [15:0] load_addr [$];
      int          found;
      string       text;
      nbf_rec      = '0;
      nbf_rec_v    = 1'b0;
      proc_cmd     = '0;
      proc_cmd_v   = 1'b0;
      gaps_on      = 1'b0;
      model_finish = 1'b0;
      stim_state   = 32'd71;
      foreach (written[i])
         written[i] = 1'b0;
      arst_n_i = 1'b0;
      repeat (10) @(posedge clk_i);
      #10;
      arst_n_i = 1'b1;

      // Program load through the NBF stream
      for (int i = 0; i < n_load; i++)
      begin
         stim_state = xorshift(stim_state);
         rec.op     = NBF_WRITE;
         rec.addr   = {8'h00, stim_state[7:0]};
         stim_state = xorshift(stim_state);
         rec.data   = stim_state;
         c.op       = IO_WRITE;
         c.addr     = rec.addr;
         c.data     = rec.data;
         apply_write(c);
         load_addr.push_back(rec.addr);
         send_rec(rec);
      end
      if (nbf_done)
         fail_run("nbf_done_o rose before the finish record");
      rec = '{op: NBF_FINISH, addr: '0, data: '0};
      send_rec(rec);
      while (!nbf_done)
      begin
         @(posedge clk_i);
         #10;
      end

      // Loaded words followed by words that were never written
      foreach (load_addr[i])
         send_cmd(IO_READ, load_addr[i], '0);
      found = 0;
      for (int a = `BOOT_MEM_WORDS - 1; a >= 0 && found < 8; a--)
      begin
         if (!written[a])
         begin
            send_cmd(IO_READ, 16'(a), '0);
            found++;
         end
      end
      drain_resps();

      run_mixed(n_mixed);
      drain_resps();
      gaps_on = 1'b1;
      run_mixed(n_mixed);
      drain_resps();
      gaps_on = 1'b0;

      text = "boot!\n";
      for (int i = 0; i < text.len(); i++)
      begin
         stim_state = xorshift(stim_state);
         send_cmd(IO_WRITE, `BOOT_PUTCHAR_ADDR, {stim_state[31:8], text[i]});
      end
      if (program_finish)
         fail_run("program_finish_o high before the finish write");
      send_cmd(IO_WRITE, `BOOT_FINISH_ADDR, 32'd1);
      send_cmd(IO_READ, `BOOT_FINISH_ADDR, '0);
      drain_resps();
      repeat (5) @(posedge clk_i);
      #10;

      if (!program_finish)
         fail_run("program_finish_o did not rise after the finish write");
      if (exp_char_q.size() != 0)
         fail_run("some putchar writes produced no char_v_o pulse");
      if (u_boot_top.u_checker.fail_count == 0)
      begin
         $display("TEST RESULT: PASS");
         $finish;
      end
      else
      begin
         $display("TEST RESULT: FAIL");
         $fatal(1, "bound assertions failed");
      end
   end

endmodule

//--- tb/boot_tb_checker.sv
// Bound checker on the boot top level's response channel, arbitration and finish flag
module boot_tb_checker
(
   input logic               clk_i,
   input logic               arst_n_i,
   input boot_pkg::io_resp_t resp_i,
   input logic               resp_v_i,
   input logic               resp_ready_i,
   input logic               cmd_ready_i,
   input logic               done_i,
   input logic               finish_i
);
   timeunit 1ns;
   timeprecision 1ns;

   int fail_count = 0;

   // Stalled response keeps its payload
   resp_hold_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (resp_v_i && !resp_ready_i) |=> (resp_v_i && $stable(resp_i)))
      else
      begin
         $error("proc_resp changed or dropped while stalled");
         fail_count++;
      end

   // Processor port stays closed during the load
   cmd_closed_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !done_i |-> !cmd_ready_i)
      else
      begin
         $error("proc_cmd_ready_o high before nbf_done_o");
         fail_count++;
      end

   finish_sticky_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      finish_i |=> finish_i)
      else
      begin
         $error("program_finish_o fell");
         fail_count++;
      end

endmodule

bind boot_top boot_tb_checker u_checker
(
   .clk_i        (clk_i),
   .arst_n_i     (arst_n_i),
   .resp_i       (proc_resp_o),
   .resp_v_i     (proc_resp_v_o),
   .resp_ready_i (proc_resp_ready_i),
   .cmd_ready_i  (proc_cmd_ready_o),
   .done_i       (nbf_done_o),
   .finish_i     (program_finish_o)
);

//--- source/boot_top.sv
// Boot and I/O subsystem top joining loader, arbiter, router, memory and host
module boot_top
(
   input  logic               clk_i,
   input  logic               arst_n_i,
   input  boot_pkg::nbf_rec_t nbf_rec_i,
   input  logic               nbf_rec_v_i,
   output logic               nbf_rec_ready_o,
   input  boot_pkg::io_cmd_t  proc_cmd_i,
   input  logic               proc_cmd_v_i,
   output logic               proc_cmd_ready_o,
   output boot_pkg::io_resp_t proc_resp_o,
   output logic               proc_resp_v_o,
   input  logic               proc_resp_ready_i,
   output logic               nbf_done_o,
   output logic [7:0]         char_o,
   output logic               char_v_o,
   output logic               program_finish_o
);
   import boot_pkg::*;

   io_cmd_t  nbf_cmd, io_cmd, mem_cmd, host_cmd;
   io_resp_t io_resp, mem_resp, host_resp;
   logic     nbf_cmd_v, nbf_cmd_ready, nbf_resp_v, nbf_resp_ready;
   logic     io_cmd_v, io_cmd_ready, io_resp_v, io_resp_ready;
   logic     mem_cmd_v, mem_cmd_ready, mem_resp_v, mem_resp_ready;
   logic     host_cmd_v, host_cmd_ready, host_resp_v, host_resp_ready;

   nbf_loader u_nbf_loader
   (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .rec_i (nbf_rec_i), .rec_v_i (nbf_rec_v_i), .rec_ready_o (nbf_rec_ready_o),
      .cmd_o (nbf_cmd), .cmd_v_o (nbf_cmd_v), .cmd_ready_i (nbf_cmd_ready),
      .resp_v_i (nbf_resp_v), .resp_ready_o (nbf_resp_ready),
      .done_o (nbf_done_o)
   );

   load_arbiter u_load_arbiter
   (
      .nbf_done_i (nbf_done_o),
      .nbf_cmd_i (nbf_cmd), .nbf_cmd_v_i (nbf_cmd_v), .nbf_cmd_ready_o (nbf_cmd_ready),
      .nbf_resp_v_o (nbf_resp_v), .nbf_resp_ready_i (nbf_resp_ready),
      .proc_cmd_i (proc_cmd_i), .proc_cmd_v_i (proc_cmd_v_i),
      .proc_cmd_ready_o (proc_cmd_ready_o),
      .proc_resp_o (proc_resp_o), .proc_resp_v_o (proc_resp_v_o),
      .proc_resp_ready_i (proc_resp_ready_i),
      .io_cmd_o (io_cmd), .io_cmd_v_o (io_cmd_v), .io_cmd_ready_i (io_cmd_ready),
      .io_resp_i (io_resp), .io_resp_v_i (io_resp_v), .io_resp_ready_o (io_resp_ready)
   );

   io_router u_io_router
   (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .cmd_i (io_cmd), .cmd_v_i (io_cmd_v), .cmd_ready_o (io_cmd_ready),
      .resp_o (io_resp), .resp_v_o (io_resp_v), .resp_ready_i (io_resp_ready),
      .mem_cmd_o (mem_cmd), .mem_cmd_v_o (mem_cmd_v), .mem_cmd_ready_i (mem_cmd_ready),
      .mem_resp_i (mem_resp), .mem_resp_v_i (mem_resp_v), .mem_resp_ready_o (mem_resp_ready),
      .host_cmd_o (host_cmd), .host_cmd_v_o (host_cmd_v), .host_cmd_ready_i (host_cmd_ready),
      .host_resp_i (host_resp), .host_resp_v_i (host_resp_v),
      .host_resp_ready_o (host_resp_ready)
   );

   io_mem u_io_mem
   (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .cmd_i (mem_cmd), .cmd_v_i (mem_cmd_v), .cmd_ready_o (mem_cmd_ready),
      .resp_o (mem_resp), .resp_v_o (mem_resp_v), .resp_ready_i (mem_resp_ready)
   );

   host_mmio u_host_mmio
   (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .cmd_i (host_cmd), .cmd_v_i (host_cmd_v), .cmd_ready_o (host_cmd_ready),
      .resp_o (host_resp), .resp_v_o (host_resp_v), .resp_ready_i (host_resp_ready),
      .char_o (char_o), .char_v_o (char_v_o), .program_finish_o (program_finish_o)
   );

endmodule

//--- host/host_mmio.sv
// Host MMIO block with putchar and finish registers
`include "boot_macros.svh"

module host_mmio
(
   input  logic               clk_i,
   input  logic               arst_n_i,
   input  boot_pkg::io_cmd_t  cmd_i,
   input  logic               cmd_v_i,
   output logic               cmd_ready_o,
   output boot_pkg::io_resp_t resp_o,
   output logic               resp_v_o,
   input  logic               resp_ready_i,
   output logic [7:0]         char_o,
   output logic               char_v_o,
   output logic               program_finish_o
);
   import boot_pkg::*;

   logic     resp_v_q;
   logic     char_v_q;
   logic     finish_q;
   logic     cmd_fire;
   logic     is_write;
   io_resp_t resp_q;
   logic [7:0] char_q;

   // One response outstanding at a time
   assign cmd_ready_o = ~resp_v_q;
   assign cmd_fire    = cmd_v_i & cmd_ready_o;
   assign is_write    = (cmd_i.op == IO_WRITE);

   always_ff @(posedge clk_i)
   begin
      if (cmd_fire)
      begin
         resp_q.op   <= cmd_i.op;
         resp_q.addr <= cmd_i.addr;
         resp_q.data <= is_write ? cmd_i.data : {{(`BOOT_DATA_W-1){1'b0}}, finish_q};
         char_q      <= cmd_i.data[7:0];
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         resp_v_q <= 1'b0;
         char_v_q <= 1'b0;
         finish_q <= 1'b0;
      end
      else
      begin
         if (cmd_fire)
            resp_v_q <= 1'b1;
         else if (resp_ready_i)
            resp_v_q <= 1'b0;
         char_v_q <= cmd_fire & is_write & (cmd_i.addr == `BOOT_PUTCHAR_ADDR);
         if (cmd_fire && is_write && (cmd_i.addr == `BOOT_FINISH_ADDR))
            finish_q <= 1'b1;
      end
   end

   assign resp_o           = resp_q;
   assign resp_v_o         = resp_v_q;
   assign char_o           = char_q;
   assign char_v_o         = char_v_q;
   assign program_finish_o = finish_q;

endmodule

//--- mem/io_mem.sv
// Word memory with fixed two-cycle latency and zero reads of unwritten words
`include "boot_macros.svh"

module io_mem
(
   input  logic               clk_i,
   input  logic               arst_n_i,
   input  boot_pkg::io_cmd_t  cmd_i,
   input  logic               cmd_v_i,
   output logic               cmd_ready_o,
   output boot_pkg::io_resp_t resp_o,
   output logic               resp_v_o,
   input  logic               resp_ready_i
);
   import boot_pkg::*;

   localparam int idx_w = $clog2(`BOOT_MEM_WORDS);
   localparam int use_w = $clog2(`BOOT_FIFO_DEPTH + 1);

   logic [`BOOT_DATA_W-1:0] words_q [`BOOT_MEM_WORDS];
   logic [`BOOT_MEM_WORDS-1:0] written_q;
   logic             s1_v_q;
   logic             s2_v_q;
   io_cmd_t          s1_cmd_q;
   io_resp_t         s2_resp_q;
   logic [idx_w-1:0] s1_idx;
   logic [use_w-1:0] used_q;
   logic             cmd_fire;
   logic             resp_fire;

   // Used counts commands in the pipe plus entries in the FIFO
   assign cmd_ready_o = (used_q < use_w'(`BOOT_FIFO_DEPTH));
   assign cmd_fire    = cmd_v_i & cmd_ready_o;
   assign resp_fire   = resp_v_o & resp_ready_i;
   assign s1_idx      = s1_cmd_q.addr[idx_w-1:0];

   always_ff @(posedge clk_i)
   begin
      if (cmd_fire)
         s1_cmd_q <= cmd_i;
      if (s1_v_q && (s1_cmd_q.op == IO_WRITE))
         words_q[s1_idx] <= s1_cmd_q.data;
      s2_resp_q.op   <= s1_cmd_q.op;
      s2_resp_q.addr <= s1_cmd_q.addr;
      if (s1_cmd_q.op == IO_WRITE)
         s2_resp_q.data <= s1_cmd_q.data;
      else
         s2_resp_q.data <= written_q[s1_idx] ? words_q[s1_idx] : '0;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         s1_v_q    <= 1'b0;
         s2_v_q    <= 1'b0;
         written_q <= '0;
         used_q    <= '0;
      end
      else
      begin
         s1_v_q <= cmd_fire;
         s2_v_q <= s1_v_q;
         if (s1_v_q && (s1_cmd_q.op == IO_WRITE))
            written_q[s1_idx] <= 1'b1;
         if (cmd_fire && !resp_fire)
            used_q <= used_q + 1'b1;
         else if (!cmd_fire && resp_fire)
            used_q <= used_q - 1'b1;
      end
   end

   // Room is reserved at accept time, so the push never stalls
   io_fifo
   #(
      .elem_t (io_resp_t),
      .depth  (`BOOT_FIFO_DEPTH)
   )
   u_resp_fifo
   (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .data_i   (s2_resp_q),
      .v_i      (s2_v_q),
      .ready_o  (),
      .data_o   (resp_o),
      .v_o      (resp_v_o),
      .ready_i  (resp_ready_i)
   );

endmodule

//--- source/io_router.sv
// Address router to memory or host, returning responses in command order
`include "boot_macros.svh"

module io_router
(
   input  logic               clk_i,
   input  logic               arst_n_i,
   input  boot_pkg::io_cmd_t  cmd_i,
   input  logic               cmd_v_i,
   output logic               cmd_ready_o,
   output boot_pkg::io_resp_t resp_o,
   output logic               resp_v_o,
   input  logic               resp_ready_i,
   output boot_pkg::io_cmd_t  mem_cmd_o,
   output logic               mem_cmd_v_o,
   input  logic               mem_cmd_ready_i,
   input  boot_pkg::io_resp_t mem_resp_i,
   input  logic               mem_resp_v_i,
   output logic               mem_resp_ready_o,
   output boot_pkg::io_cmd_t  host_cmd_o,
   output logic               host_cmd_v_o,
   input  logic               host_cmd_ready_i,
   input  boot_pkg::io_resp_t host_resp_i,
   input  logic               host_resp_v_i,
   output logic               host_resp_ready_o
);

   logic to_host;
   logic tag_ready;
   logic head_host;
   logic head_v;

   // Host region sits at the top of the address space
   assign to_host = (cmd_i.addr >= `BOOT_HOST_BASE);

   assign cmd_ready_o  = tag_ready & (to_host ? host_cmd_ready_i : mem_cmd_ready_i);
   assign mem_cmd_o    = cmd_i;
   assign host_cmd_o   = cmd_i;
   assign mem_cmd_v_o  = cmd_v_i & ~to_host & tag_ready;
   assign host_cmd_v_o = cmd_v_i & to_host & tag_ready;

   // Each accepted command pushes a tag that pops when its response leaves
   io_fifo
   #(
      .elem_t (logic),
      .depth  (`BOOT_FIFO_DEPTH)
   )
   u_order_fifo
   (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .data_i   (to_host),
      .v_i      (cmd_v_i & cmd_ready_o),
      .ready_o  (tag_ready),
      .data_o   (head_host),
      .v_o      (head_v),
      .ready_i  (resp_v_o & resp_ready_i)
   );

   // Only the target named by the head tag may answer
   assign resp_o            = head_host ? host_resp_i : mem_resp_i;
   assign resp_v_o          = head_v & (head_host ? host_resp_v_i : mem_resp_v_i);
   assign mem_resp_ready_o  = head_v & ~head_host & resp_ready_i;
   assign host_resp_ready_o = head_v & head_host & resp_ready_i;

endmodule

//--- source/load_arbiter.sv
// Fixed arbiter handing the command channel to the loader, then the processor
module load_arbiter
(
   input  logic               nbf_done_i,
   input  boot_pkg::io_cmd_t  nbf_cmd_i,
   input  logic               nbf_cmd_v_i,
   output logic               nbf_cmd_ready_o,
   output logic               nbf_resp_v_o,
   input  logic               nbf_resp_ready_i,
   input  boot_pkg::io_cmd_t  proc_cmd_i,
   input  logic               proc_cmd_v_i,
   output logic               proc_cmd_ready_o,
   output boot_pkg::io_resp_t proc_resp_o,
   output logic               proc_resp_v_o,
   input  logic               proc_resp_ready_i,
   output boot_pkg::io_cmd_t  io_cmd_o,
   output logic               io_cmd_v_o,
   input  logic               io_cmd_ready_i,
   input  boot_pkg::io_resp_t io_resp_i,
   input  logic               io_resp_v_i,
   output logic               io_resp_ready_o
);

   // Loader traffic drains before done rises, so steering by done is enough
   always_comb
   begin
      proc_resp_o = io_resp_i;
      if (nbf_done_i)
      begin
         io_cmd_o         = proc_cmd_i;
         io_cmd_v_o       = proc_cmd_v_i;
         proc_cmd_ready_o = io_cmd_ready_i;
         nbf_cmd_ready_o  = 1'b0;
         proc_resp_v_o    = io_resp_v_i;
         nbf_resp_v_o     = 1'b0;
         io_resp_ready_o  = proc_resp_ready_i;
      end
      else
      begin
         io_cmd_o         = nbf_cmd_i;
         io_cmd_v_o       = nbf_cmd_v_i;
         proc_cmd_ready_o = 1'b0;
         nbf_cmd_ready_o  = io_cmd_ready_i;
         proc_resp_v_o    = 1'b0;
         nbf_resp_v_o     = io_resp_v_i;
         io_resp_ready_o  = nbf_resp_ready_i;
      end
   end

endmodule

//--- loader/nbf_loader.sv
// NBF loader turning load records into memory writes and flagging completion
module nbf_loader
(
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  boot_pkg::nbf_rec_t rec_i,
   input  logic              rec_v_i,
   output logic              rec_ready_o,
   output boot_pkg::io_cmd_t cmd_o,
   output logic              cmd_v_o,
   input  logic              cmd_ready_i,
   input  logic              resp_v_i,
   output logic              resp_ready_o,
   output logic              done_o
);
   import boot_pkg::*;

   localparam int cnt_w = 8;

   logic             seen_finish_q;
   logic             done_q;
   logic [cnt_w-1:0] pending_q;
   logic             is_finish;
   logic             cmd_fire;
   logic             resp_fire;

   assign is_finish = (rec_i.op == NBF_FINISH);

   // Write records pass straight through and finish is swallowed here
   assign cmd_o.op   = IO_WRITE;
   assign cmd_o.addr = rec_i.addr;
   assign cmd_o.data = rec_i.data;
   assign cmd_v_o    = rec_v_i & ~is_finish & ~seen_finish_q;

   assign rec_ready_o  = ~seen_finish_q & (is_finish | cmd_ready_i);
   assign resp_ready_o = 1'b1;

   assign cmd_fire  = cmd_v_o & cmd_ready_i;
   assign resp_fire = resp_v_i & resp_ready_o;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         seen_finish_q <= 1'b0;
         done_q        <= 1'b0;
         pending_q     <= '0;
      end
      else
      begin
         if (rec_v_i && rec_ready_o && is_finish)
            seen_finish_q <= 1'b1;

         // Outstanding write acks
         if (cmd_fire && !resp_fire)
            pending_q <= pending_q + 1'b1;
         else if (!cmd_fire && resp_fire)
            pending_q <= pending_q - 1'b1;

         // Sticky once everything is acknowledged
         if (seen_finish_q && (pending_q == '0))
            done_q <= 1'b1;
      end
   end

   assign done_o = done_q;

endmodule

//--- source/io_fifo.sv
// Small valid/ready FIFO built as a circular buffer with an occupancy count
module io_fifo
#(
   parameter type elem_t = logic,
   parameter int  depth  = 4
)
(
   input  logic  clk_i,
   input  logic  arst_n_i,
   input  elem_t data_i,
   input  logic  v_i,
   output logic  ready_o,
   output elem_t data_o,
   output logic  v_o,
   input  logic  ready_i
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   elem_t            mem_q [depth];
   logic [ptr_w-1:0] wr_ptr_q;
   logic [ptr_w-1:0] rd_ptr_q;
   logic [cnt_w-1:0] count_q;
   logic             push;
   logic             pop;

   assign ready_o = (count_q != cnt_w'(depth));
   assign v_o     = (count_q != '0);
   assign data_o  = mem_q[rd_ptr_q];
   assign push    = v_i & ready_o;
   assign pop     = v_o & ready_i;

   always_ff @(posedge clk_i)
   begin
      if (push)
         mem_q[wr_ptr_q] <= data_i;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
         if (push && !pop)
            count_q <= count_q + 1'b1;
         else if (pop && !push)
            count_q <= count_q - 1'b1;
      end
   end

endmodule

//--- common/boot_pkg.sv
// Boot subsystem types for I/O commands, responses and NBF load records
`include "boot_macros.svh"

package boot_pkg;

   typedef enum logic
   {
      IO_READ  = 1'b0,
      IO_WRITE = 1'b1
   } io_op_e;

   typedef enum logic
   {
      NBF_WRITE  = 1'b0,
      NBF_FINISH = 1'b1
   } nbf_op_e;

   // Command into memory or host
   typedef struct packed
   {
      io_op_e                  op;
      logic [`BOOT_ADDR_W-1:0] addr;
      logic [`BOOT_DATA_W-1:0] data;
   } io_cmd_t;

   // Read data on a read, echoed write data on a write
   typedef struct packed
   {
      io_op_e                  op;
      logic [`BOOT_ADDR_W-1:0] addr;
      logic [`BOOT_DATA_W-1:0] data;
   } io_resp_t;

   // One record of the load stream
   typedef struct packed
   {
      nbf_op_e                 op;
      logic [`BOOT_ADDR_W-1:0] addr;
      logic [`BOOT_DATA_W-1:0] data;
   } nbf_rec_t;

endpackage

//--- common/boot_macros.svh
// Boot subsystem widths, memory depth, host register map and FIFO depth
`ifndef BOOT_MACROS_SVH
`define BOOT_MACROS_SVH

// Bus widths
`define BOOT_ADDR_W 16
`define BOOT_DATA_W 32

// Word memory depth
`define BOOT_MEM_WORDS 256

// Host region and its registers
`define BOOT_HOST_BASE    16'h8000
`define BOOT_PUTCHAR_ADDR 16'h8000
`define BOOT_FINISH_ADDR  16'h8004

`define BOOT_FIFO_DEPTH 4

`endif
